//--- hdl/memlink_pkg.sv
// Widths, types and address map of the memory endpoint
// Addresses are byte addresses; memory words ignore the low two bits
// Everything at or above MEM_LIMIT belongs to the host block
package memlink_pkg;

  localparam int ADDR_W    = 12;
  localparam int DATA_W    = 32;
  localparam int TAG_W     = 4;
  localparam int NUM_CORES = 4;
  localparam int TRACE_W   = 8;
  localparam int MEM_WORDS = 256;
  localparam int IDX_W     = $clog2(MEM_WORDS);

  // Word index position inside a byte address
  localparam int IDX_LSB = 2;

  // Byte address of a request
  typedef logic [ADDR_W-1:0] addr_t;

  // Request and response data
  typedef logic [DATA_W-1:0] data_t;

  // Echoed back on the response
  typedef logic [TAG_W-1:0] tag_t;

  typedef logic [IDX_W-1:0] word_idx_t;

  // One sticky bit per core
  typedef logic [NUM_CORES-1:0] finish_t;

  typedef logic [TRACE_W-1:0] trace_en_t;

  // Address map
  localparam addr_t MEM_LIMIT   = 12'h400;
  localparam addr_t FINISH_ADDR = 12'h800;
  localparam addr_t TRACE_ADDR  = 12'h804;

endpackage

//--- hdl/req_if.sv
// One decoded request from the decoder to a target
// Transfers when valid and ready are both high; fields hold until then
`timescale 1ns/1ps

interface req_if;
  import memlink_pkg::*;

  logic  valid;
  logic  ready;
  logic  wr;
  addr_t addr;
  tag_t  tag;
  data_t data;

  modport src (output valid, output wr, output addr, output tag, output data,
               input ready);

  modport dst (input valid, input wr, input addr, input tag, input data,
               output ready);

endinterface

//--- hdl/rsp_if.sv
// One response from a target to the reverse queue
// Transfers when valid and ready are both high; fields hold until then
`timescale 1ns/1ps

interface rsp_if;
  import memlink_pkg::*;

  logic  valid;
  logic  ready;
  tag_t  tag;
  data_t data;
  logic  err;

  modport src (output valid, output tag, output data, output err, input ready);

  modport dst (input valid, input tag, input data, input err, output ready);

endinterface

//--- hdl/fwd_decoder.sv
// Holds one forward request and offers it to the target chosen by address
// Sender must keep fields stable until the request transfers
`timescale 1ns/1ps

module fwd_decoder
  (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               fwd_v_i,
  input  logic               fwd_wr_i,
  input  memlink_pkg::addr_t fwd_addr_i,
  input  memlink_pkg::tag_t  fwd_tag_i,
  input  memlink_pkg::data_t fwd_data_i,
  output logic               fwd_ready_o,
  req_if.src                 mem_req,
  req_if.src                 host_req
  );
  import memlink_pkg::*;

  logic  full_q;
  logic  host_q;
  logic  wr_q;
  addr_t addr_q;
  tag_t  tag_q;
  data_t data_q;
  logic  drain;
  logic  accept;

  // Selected target takes the held request this cycle
  assign drain       = full_q & (host_q ? host_req.ready : mem_req.ready);
  assign fwd_ready_o = ~full_q | drain;
  assign accept      = fwd_v_i & fwd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      full_q <= 1'b0;
    else if (accept)
      full_q <= 1'b1;
    else if (drain)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      host_q <= (fwd_addr_i >= MEM_LIMIT);
      wr_q   <= fwd_wr_i;
      addr_q <= fwd_addr_i;
      tag_q  <= fwd_tag_i;
      data_q <= fwd_data_i;
    end
  end

  assign mem_req.valid  = full_q & ~host_q;
  assign mem_req.wr     = wr_q;
  assign mem_req.addr   = addr_q;
  assign mem_req.tag    = tag_q;
  assign mem_req.data   = data_q;

  assign host_req.valid = full_q & host_q;
  assign host_req.wr    = wr_q;
  assign host_req.addr  = addr_q;
  assign host_req.tag   = tag_q;
  assign host_req.data  = data_q;

endmodule

//--- hdl/mem_store.sv
// Word memory target; address bits 9:2 select the word
// Contents are undefined until written
`timescale 1ns/1ps

module mem_store
  (
  input  logic clk_i,
  input  logic rst_i,
  req_if.dst   req,
  rsp_if.src   rsp
  );
  import memlink_pkg::*;

  data_t     mem [MEM_WORDS];
  word_idx_t idx;
  logic      accept;
  logic      valid_q;
  tag_t      tag_q;
  data_t     data_q;

  assign idx       = req.addr[IDX_LSB +: IDX_W];
  assign req.ready = ~valid_q | rsp.ready;
  assign accept    = req.valid & req.ready;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_q <= 1'b0;
    else if (accept)
      valid_q <= 1'b1;
    else if (rsp.ready)
      valid_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (req.wr)
        mem[idx] <= req.data;
      tag_q  <= req.tag;
      // Writes answer with zero data
      data_q <= req.wr ? '0 : mem[idx];
    end
  end

  assign rsp.valid = valid_q;
  assign rsp.tag   = tag_q;
  assign rsp.data  = data_q;
  assign rsp.err   = 1'b0;

endmodule

//--- hdl/host_regs.sv
// Host device target with sticky finish bits and trace enables
// Only FINISH_ADDR and TRACE_ADDR are mapped; others answer with err
`timescale 1ns/1ps

module host_regs
  (
  input  logic                   clk_i,
  input  logic                   rst_i,
  req_if.dst                     req,
  rsp_if.src                     rsp,
  output memlink_pkg::finish_t   finish_o,
  output memlink_pkg::trace_en_t trace_en_o
  );
  import memlink_pkg::*;

  finish_t   finish_q;
  trace_en_t trace_q;
  logic      hit_finish;
  logic      hit_trace;
  logic      accept;
  logic      valid_q;
  tag_t      tag_q;
  data_t     data_q;
  logic      err_q;
  data_t     rd_data;

  assign hit_finish = (req.addr == FINISH_ADDR);
  assign hit_trace  = (req.addr == TRACE_ADDR);
  assign req.ready  = ~valid_q | rsp.ready;
  assign accept     = req.valid & req.ready;

  // Read value before any write in the same cycle
  assign rd_data = hit_finish ? data_t'(finish_q) :
                   hit_trace  ? data_t'(trace_q)  : '0;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      finish_q <= '0;
      trace_q  <= '0;
      valid_q  <= 1'b0;
    end
    else
    begin
      if (accept && req.wr && hit_finish)
        finish_q <= finish_q | req.data[NUM_CORES-1:0];
      if (accept && req.wr && hit_trace)
        trace_q <= req.data[TRACE_W-1:0];
      if (accept)
        valid_q <= 1'b1;
      else if (rsp.ready)
        valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      tag_q  <= req.tag;
      err_q  <= ~(hit_finish | hit_trace);
      data_q <= req.wr ? '0 : rd_data;
    end
  end

  assign rsp.valid  = valid_q;
  assign rsp.tag    = tag_q;
  assign rsp.data   = data_q;
  assign rsp.err    = err_q;
  assign finish_o   = finish_q;
  assign trace_en_o = trace_q;

endmodule

//--- hdl/rev_queue.sv
// Two-entry reverse FIFO fed by the memory and host responses
// Memory wins when both offer; one response enters per cycle
`timescale 1ns/1ps

module rev_queue
  (
  input  logic               clk_i,
  input  logic               rst_i,
  rsp_if.dst                 mem_rsp,
  rsp_if.dst                 host_rsp,
  output logic               rev_v_o,
  output logic               rev_err_o,
  output memlink_pkg::tag_t  rev_tag_o,
  output memlink_pkg::data_t rev_data_o,
  input  logic               rev_ready_i
  );
  import memlink_pkg::*;

  tag_t       tag_q  [2];
  data_t      data_q [2];
  logic       err_q  [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       space;
  logic       push;
  logic       pop;

  assign space          = (count_q != 2'd2);
  assign mem_rsp.ready  = space;
  assign host_rsp.ready = space & ~mem_rsp.valid;
  assign push           = space & (mem_rsp.valid | host_rsp.valid);
  assign pop            = rev_v_o & rev_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      if (push && !pop)
        count_q <= count_q + 2'd1;
      else if (pop && !push)
        count_q <= count_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      tag_q[wr_ptr_q]  <= mem_rsp.valid ? mem_rsp.tag  : host_rsp.tag;
      data_q[wr_ptr_q] <= mem_rsp.valid ? mem_rsp.data : host_rsp.data;
      err_q[wr_ptr_q]  <= mem_rsp.valid ? mem_rsp.err  : host_rsp.err;
    end
  end

  // Head entry drives the reverse channel
  assign rev_v_o    = (count_q != 2'd0);
  assign rev_tag_o  = tag_q[rd_ptr_q];
  assign rev_data_o = data_q[rd_ptr_q];
  assign rev_err_o  = err_q[rd_ptr_q];

endmodule

//--- hdl/memlink_top.sv
// Memory-side endpoint: forward requests in, tagged responses out
// Responses may return out of request order; the tag matches them
`timescale 1ns/1ps

module memlink_top
  (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          fwd_v_i,
  input  logic                          fwd_wr_i,
  input  memlink_pkg::addr_t            fwd_addr_i,
  input  memlink_pkg::tag_t             fwd_tag_i,
  input  memlink_pkg::data_t            fwd_data_i,
  output logic                          fwd_ready_o,
  output logic                          rev_v_o,
  output memlink_pkg::tag_t             rev_tag_o,
  output memlink_pkg::data_t            rev_data_o,
  output logic                          rev_err_o,
  input  logic                          rev_ready_i,
  output memlink_pkg::finish_t          finish_o,
  output memlink_pkg::trace_en_t        trace_en_o
  );

  req_if mem_req ();
  req_if host_req ();
  rsp_if mem_rsp ();
  rsp_if host_rsp ();

  fwd_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fwd_v_i     (fwd_v_i),
    .fwd_wr_i    (fwd_wr_i),
    .fwd_addr_i  (fwd_addr_i),
    .fwd_tag_i   (fwd_tag_i),
    .fwd_data_i  (fwd_data_i),
    .fwd_ready_o (fwd_ready_o),
    .mem_req     (mem_req),
    .host_req    (host_req)
  );

  mem_store i_mem (.clk_i(clk_i), .rst_i(rst_i), .req(mem_req), .rsp(mem_rsp));

  host_regs i_host (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req        (host_req),
    .rsp        (host_rsp),
    .finish_o   (finish_o),
    .trace_en_o (trace_en_o)
  );

  rev_queue i_rev (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_rsp     (mem_rsp),
    .host_rsp    (host_rsp),
    .rev_v_o     (rev_v_o),
    .rev_err_o   (rev_err_o),
    .rev_tag_o   (rev_tag_o),
    .rev_data_o  (rev_data_o),
    .rev_ready_i (rev_ready_i)
  );

endmodule

//--- tests/memlink_properties.sv
// Concurrent checks on the reverse channel and the host status outputs
// Attached to memlink_top by bind
`timescale 1ns/1ps

module memlink_properties
  (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 fwd_ready_o,
  input logic                 rev_v_o,
  input logic                 rev_ready_i,
  input logic                 rev_err_o,
  input memlink_pkg::tag_t    rev_tag_o,
  input memlink_pkg::data_t   rev_data_o,
  input memlink_pkg::finish_t finish_o
  );

  a_rev_idle: assert property (@(posedge clk_i) rst_i |=> !rev_v_o)
    else $error("rev_v_o high in the cycle after reset");

  a_fwd_ready: assert property (@(posedge clk_i) rst_i |=> fwd_ready_o)
    else $error("fwd_ready_o low in the cycle after reset");

  // Head entry holds while the sink stalls
  a_rev_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rev_v_o && !rev_ready_i |=> rev_v_o && $stable(rev_tag_o) &&
    $stable(rev_data_o) && $stable(rev_err_o))
    else $error("reverse fields changed while stalled");

  a_finish_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> (finish_o & $past(finish_o)) == $past(finish_o))
    else $error("finish_o bit cleared without reset");

endmodule

bind memlink_top memlink_properties i_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .fwd_ready_o (fwd_ready_o),
  .rev_v_o     (rev_v_o),
  .rev_ready_i (rev_ready_i),
  .rev_err_o   (rev_err_o),
  .rev_tag_o   (rev_tag_o),
  .rev_data_o  (rev_data_o),
  .finish_o    (finish_o)
);

//--- tests/memlink_tb.sv
// Random request stream checked against a tag-keyed reference model
// Reads target only memory words written earlier in the run
`timescale 1ns/1ps

module memlink_tb;
  import memlink_pkg::*;

  localparam int NUM_REQ    = 600;
  localparam int RESET_CYC  = 16;
  localparam int MAX_CYCLES = RESET_CYC + NUM_REQ * 24;
  localparam int NUM_TAGS   = 1 << TAG_W;

  logic      clk_i;
  logic      rst_i;
  logic      fwd_v_i;
  logic      fwd_wr_i;
  addr_t     fwd_addr_i;
  tag_t      fwd_tag_i;
  data_t     fwd_data_i;
  logic      fwd_ready_o;
  logic      rev_v_o;
  tag_t      rev_tag_o;
  data_t     rev_data_o;
  logic      rev_err_o;
  logic      rev_ready_i;
  finish_t   finish_o;
  trace_en_t trace_en_o;

  // Reference model state
  data_t     mem_m     [MEM_WORDS];
  logic      written_m [MEM_WORDS];
  finish_t   finish_m;
  trace_en_t trace_m;

  // Per-tag expected responses
  logic      issued_t   [NUM_TAGS];
  logic      inflight_t [NUM_TAGS];
  data_t     exp_data   [NUM_TAGS];
  logic      exp_err    [NUM_TAGS];
  logic      fin_chk    [NUM_TAGS];
  finish_t   exp_fin    [NUM_TAGS];
  logic      trc_chk    [NUM_TAGS];
  tag_t      last_trc_tag;

  // Sampled at the falling edge and used on the next rising edge
  logic      fwd_fire_s;
  logic      rev_fire_s;
  tag_t      rev_tag_s;
  data_t     rev_data_s;
  logic      rev_err_s;
  finish_t   finish_s;
  trace_en_t trace_s;

  logic [31:0] rng;
  int          errors;
  int          checks;
  int          issued;
  int          responses;
  int          cycles;

  memlink_top i_dut (.*);

  always #20 clk_i = ~clk_i;

  always @(negedge clk_i)
  begin
    fwd_fire_s = fwd_v_i & fwd_ready_o;
    rev_fire_s = rev_v_o & rev_ready_i;
    rev_tag_s  = rev_tag_o;
    rev_data_s = rev_data_o;
    rev_err_s  = rev_err_o;
    finish_s   = finish_o;
    trace_s    = trace_en_o;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Expected response computed in transfer order
  task automatic model_request(input logic wr, input addr_t addr, input tag_t tag,
                               input data_t data);
    word_idx_t idx;
    idx           = addr[IDX_LSB +: IDX_W];
    exp_data[tag] = '0;
    exp_err[tag]  = 1'b0;
    fin_chk[tag]  = 1'b0;
    trc_chk[tag]  = 1'b0;
    if (addr < MEM_LIMIT)
    begin
      if (wr)
        mem_m[idx] = data;
      else
        exp_data[tag] = mem_m[idx];
    end
    else if (addr == FINISH_ADDR)
    begin
      if (wr)
      begin
        finish_m     = finish_m | data[NUM_CORES-1:0];
        fin_chk[tag] = 1'b1;
        exp_fin[tag] = finish_m;
      end
      else
        exp_data[tag] = data_t'(finish_m);
    end
    else if (addr == TRACE_ADDR)
    begin
      if (wr)
      begin
        trace_m      = data[TRACE_W-1:0];
        trc_chk[tag] = 1'b1;
        last_trc_tag = tag;
      end
      else
        exp_data[tag] = data_t'(trace_m);
    end
    else
      exp_err[tag] = 1'b1;
    inflight_t[tag] = 1'b1;
  endtask

  task automatic check_response();
    if (!inflight_t[rev_tag_s])
    begin
      errors++;
      $display("Response at %0t carries tag %0d, which is not outstanding",
               $time, rev_tag_s);
    end
    else
    begin
      check_value("rev_data_o", rev_data_s, exp_data[rev_tag_s]);
      check_value("rev_err_o", data_t'(rev_err_s), data_t'(exp_err[rev_tag_s]));
      // Finish bits are sticky, so later writes may add bits
      if (fin_chk[rev_tag_s])
        check_value("finish_o", data_t'(finish_s & exp_fin[rev_tag_s]),
                    data_t'(exp_fin[rev_tag_s]));
      // A later trace write may already be applied
      if (trc_chk[rev_tag_s] && last_trc_tag == rev_tag_s)
        check_value("trace_en_o", data_t'(trace_s), data_t'(trace_m));
      inflight_t[rev_tag_s] = 1'b0;
      issued_t[rev_tag_s]   = 1'b0;
    end
    responses++;
  endtask

  task automatic issue_request();
    logic [31:0] r;
    tag_t        tag;
    word_idx_t   idx;
    addr_t       addr;
    logic        wr;
    data_t       data;
    int          i;
    rng = xorshift32(rng);
    r   = rng;
    rng = xorshift32(rng);
    tag = r[31:28];
    for (i = 0; i < NUM_TAGS && issued_t[tag]; i++)
      tag = tag + 4'd1;
    if (issued_t[tag])
      return;
    idx  = r[11:4];
    addr = {2'b00, idx, r[13:12]};
    wr   = r[14];
    data = rng;
    if (r[3:0] < 4'd10)
    begin
      // Unwritten words are written first
      wr            = wr | !written_m[idx];
      written_m[idx] = 1'b1;
    end
    else if (r[3:0] < 4'd12)
    begin
      addr = FINISH_ADDR;
      data = {rng[31:4], 4'b0001 << r[17:16]};
    end
    else if (r[3:0] < 4'd14)
      addr = TRACE_ADDR;
    else
    begin
      addr = r[27:16] | MEM_LIMIT;
      if (addr == FINISH_ADDR || addr == TRACE_ADDR)
        addr = 12'hffc;
    end
    issued_t[tag] = 1'b1;
    issued++;
    fwd_v_i    <= 1'b1;
    fwd_wr_i   <= wr;
    fwd_addr_i <= addr;
    fwd_tag_i  <= tag;
    fwd_data_i <= data;
  endtask

  task automatic drive_cycle();
    if (rev_fire_s)
      check_response();
    if (fwd_fire_s)
    begin
      model_request(fwd_wr_i, fwd_addr_i, fwd_tag_i, fwd_data_i);
      fwd_v_i <= 1'b0;
    end
    rng = xorshift32(rng);
    rev_ready_i <= (rng[2:0] > 3'd2);
    if ((!fwd_v_i || fwd_fire_s) && issued < NUM_REQ && rng[4:3] != 2'b00)
      issue_request();
  endtask

  task automatic finish_run();
    $display("Run ended after %0d cycles: %0d requests, %0d responses, %0d checks, %0d errors",
             cycles, issued, responses, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  initial
  begin
    int i;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    fwd_v_i      = 1'b0;
    fwd_wr_i     = 1'b0;
    fwd_addr_i   = '0;
    fwd_tag_i    = '0;
    fwd_data_i   = '0;
    rev_ready_i  = 1'b0;
    fwd_fire_s   = 1'b0;
    rev_fire_s   = 1'b0;
    rng          = 32'h1e05;
    finish_m     = '0;
    trace_m      = '0;
    last_trc_tag = '0;
    errors       = 0;
    checks       = 0;
    issued       = 0;
    responses    = 0;
    for (i = 0; i < MEM_WORDS; i++)
      written_m[i] = 1'b0;
    for (i = 0; i < NUM_TAGS; i++)
    begin
      issued_t[i]   = 1'b0;
      inflight_t[i] = 1'b0;
    end
    repeat (RESET_CYC) @(posedge clk_i);
    rst_i <= 1'b0;
    cycles = RESET_CYC;
    @(negedge clk_i);
    check_value("rev_v_o", data_t'(rev_v_o), 32'd0);
    check_value("fwd_ready_o", data_t'(fwd_ready_o), 32'd1);
    check_value("finish_o", data_t'(finish_o), 32'd0);
    check_value("trace_en_o", data_t'(trace_en_o), 32'd0);
    while (responses < NUM_REQ && cycles < MAX_CYCLES)
    begin
      @(posedge clk_i);
      cycles++;
      drive_cycle();
    end
    if (responses < NUM_REQ)
    begin
      errors++;
      $display("Timeout: only %0d of %0d responses arrived within %0d cycles",
               responses, NUM_REQ, MAX_CYCLES);
    end
    else
    begin
      repeat (4) @(negedge clk_i);
      check_value("rev_v_o", data_t'(rev_v_o), 32'd0);
      check_value("finish_o", data_t'(finish_o), data_t'(finish_m));
      check_value("trace_en_o", data_t'(trace_en_o), data_t'(trace_m));
      for (i = 0; i < NUM_TAGS; i++)
      begin
        if (issued_t[i])
        begin
          errors++;
          $display("Tag %0d is still outstanding at the end of the run", i);
        end
      end
    end
    finish_run();
  end

endmodule

//--- flist.f
hdl/memlink_pkg.sv
hdl/req_if.sv
hdl/rsp_if.sv
hdl/fwd_decoder.sv
hdl/mem_store.sv
hdl/host_regs.sv
hdl/rev_queue.sv
hdl/memlink_top.sv
tests/memlink_properties.sv
tests/memlink_tb.sv

//--- Makefile
BUILD = obj_dir

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert --top-module memlink_tb \
	  -Mdir $(BUILD) -o Vmemlink_tb -f flist.f

run: build
	$(BUILD)/Vmemlink_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Finished with errors" sim.log

clean:
	rm -rf $(BUILD) sim.log
